// File: ro_cache.f
common/ro_cache_cfg_pkg.sv
common/ro_cache_ctrl_pkg.sv
common/ro_fetch_if.sv
verilog/ro_region_select.sv
ro_cache/ro_cache_lookup.sv
ro_cache/ro_cache_refill.sv
verilog/ro_mem_arbiter.sv
verilog/ro_cache_top.sv
bench/ro_tb_clock.sv
bench/ro_cache_chk.sv
bench/ro_cache_tb.sv

// File: Makefile
# Verilator build and run of the read-only cache testbench
# The error limit lets the testbench end a failing run itself

TOP := ro_cache_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ro_cache.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: bench/ro_cache_tb.sv
// Read-only cache testbench
// Drives CPU reads and flushes, models the memory port and checks each response

`timescale 1ns/1ps
`default_nettype none

module ro_cache_tb
  import ro_cache_cfg_pkg::*;
();

  localparam int unsigned WAIT_TIMEOUT = 200;
  localparam int unsigned HIT_LATENCY  = 3;
  localparam data_t       DATA_MASK    = 32'h5a5a_0000;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     enable_i;
  addr_t [REGION_COUNT-1:0] region_start_i;
  addr_t [REGION_COUNT-1:0] region_end_i;
  logic                     cpu_req_i;
  addr_t                    cpu_addr_i;
  logic                     cpu_ack_o;
  data_t                    cpu_data_o;
  logic                     cpu_error_o;
  logic                     flush_req_i;
  logic                     flush_ack_o;
  logic                     mem_req_o;
  addr_t                    mem_addr_o;
  logic                     mem_ack_i;
  data_t                    mem_data_i;
  logic                     mem_error_i;

  // Memory model state
  logic        mem_busy;
  int unsigned mem_delay;
  int unsigned mem_count;

  ro_tb_clock ro_tb_clock_i (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  ro_cache_top ro_cache_top_i (.*);

  // Reference rules of the memory
  function automatic data_t model_data(input addr_t addr);
    return addr ^ DATA_MASK;
  endfunction

  // Top 256 bytes of each region answer with an error
  function automatic logic model_error(input addr_t addr);
    logic err;
    err = 1'b0;
    for (int r = 0; r < REGION_COUNT; r++) begin
      if (addr >= region_end_i[r] - 32'd256 && addr < region_end_i[r]) begin
        err = 1'b1;
      end
    end
    return err;
  endfunction

  // --------------------
  // Memory model
  // --------------------
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_ack_i   <= 1'b0;
      mem_data_i  <= '0;
      mem_error_i <= 1'b0;
      mem_busy    <= 1'b0;
      mem_delay   <= 0;
      mem_count   <= 0;
    end else if (mem_ack_i) begin
      if (!mem_req_o) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_busy) begin
      if (mem_delay == 0) begin
        mem_busy    <= 1'b0;
        mem_ack_i   <= 1'b1;
        mem_data_i  <= model_data(mem_addr_o);
        mem_error_i <= model_error(mem_addr_o);
        mem_count   <= mem_count + 1;
      end else begin
        mem_delay <= mem_delay - 1;
      end
    end else if (mem_req_o) begin
      // Ack 1 to 4 cycles after the request is seen
      mem_busy  <= 1'b1;
      mem_delay <= $urandom_range(3, 0);
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    fail_run("A read result does not match its expected value");
  endtask

  // Bound checker failures end the run here
  always @(posedge clk_i) begin
    if (ro_cache_top_i.ro_cache_chk_i.fail_count != 0) begin
      fail_run("A protocol assertion on the DUT ports failed");
    end
  end

  task automatic wait_reset_release();
    int unsigned cycles;
    cycles = 0;
    while (arst_n_i !== 1'b1) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_TIMEOUT) fail_run("Reset was never released");
    end
  endtask

  // One CPU read, checked for data, error, handshake count and hit latency
  task automatic read_check(input addr_t addr, input int unsigned exp_mem,
                            input logic exp_hit);
    int unsigned cycles;
    int unsigned mem_before;
    data_t       got_data;
    logic        got_error;
    mem_before = mem_count;
    cpu_addr_i <= addr;
    cpu_req_i  <= 1'b1;
    @(posedge clk_i);
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_TIMEOUT) fail_run("Timeout waiting for the CPU ack to rise");
    end while (!cpu_ack_o);
    got_data  = cpu_data_o;
    got_error = cpu_error_o;
    cpu_req_i <= 1'b0;
    if (exp_hit) begin
      assert (cycles == HIT_LATENCY)
        else report_mismatch("cpu_ack_o latency", cycles, HIT_LATENCY);
    end
    assert (got_data === model_data(addr))
      else report_mismatch("cpu_data_o", got_data, model_data(addr));
    assert (got_error === model_error(addr))
      else report_mismatch("cpu_error_o", 32'(got_error), 32'(model_error(addr)));
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_TIMEOUT) fail_run("Timeout waiting for the CPU ack to fall");
    end while (cpu_ack_o);
    assert (mem_count - mem_before == exp_mem)
      else report_mismatch("mem_req_o handshakes", mem_count - mem_before, exp_mem);
  endtask

  task automatic flush_cache();
    int unsigned cycles;
    flush_req_i <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_TIMEOUT) fail_run("Timeout waiting for the flush ack to rise");
    end while (!flush_ack_o);
    flush_req_i <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_TIMEOUT) fail_run("Timeout waiting for the flush ack to fall");
    end while (flush_ack_o);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    void'($urandom(32'hf324));
    enable_i          = 1'b1;
    region_start_i[0] = 32'h0000_1000;
    region_end_i[0]   = 32'h0000_2000;
    region_start_i[1] = 32'h0040_0000;
    region_end_i[1]   = 32'h0040_0400;
    cpu_req_i         = 1'b0;
    cpu_addr_i        = '0;
    flush_req_i       = 1'b0;
    mem_ack_i         = 1'b0;
    mem_data_i        = '0;
    mem_error_i       = 1'b0;
    wait_reset_release();

    // Miss, then hits on both words of the line
    read_check(32'h0000_1000, LINE_WORDS, 1'b0);
    read_check(32'h0000_1000, 0, 1'b1);
    read_check(32'h0000_1004, 0, 1'b1);
    for (int i = 0; i < 4; i++) begin
      read_check(32'h0040_0014 + addr_t'(8 * i), LINE_WORDS, 1'b0);
      read_check(32'h0040_0010 + addr_t'(8 * i), 0, 1'b1);
    end

    // Outside both regions, end address is exclusive
    read_check(32'h0000_3000, 1, 1'b0);
    read_check(32'h0000_3000, 1, 1'b0);
    read_check(32'h0000_0ffc, 1, 1'b0);
    read_check(32'h0000_2000, 1, 1'b0);

    // Cache disabled, line stays valid underneath
    enable_i <= 1'b0;
    read_check(32'h0000_1000, 1, 1'b0);
    read_check(32'h0000_1000, 1, 1'b0);
    read_check(32'h0000_1f10, 1, 1'b0);
    enable_i <= 1'b1;
    read_check(32'h0000_1004, 0, 1'b1);

    flush_cache();
    read_check(32'h0000_1004, LINE_WORDS, 1'b0);
    read_check(32'h0000_1000, 0, 1'b1);

    // Error lines are never installed
    read_check(32'h0000_1f08, LINE_WORDS, 1'b0);
    read_check(32'h0000_1f08, LINE_WORDS, 1'b0);
    read_check(32'h0040_03f0, LINE_WORDS, 1'b0);
    read_check(32'h0040_03f4, LINE_WORDS, 1'b0);

    if (ro_cache_top_i.ro_cache_chk_i.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run("A protocol assertion on the DUT ports failed");
    end
  end

endmodule

`default_nettype wire

// File: bench/ro_cache_chk.sv
// Protocol checker for the read-only cache top level
// Four-phase ordering on the CPU, memory and flush ports, plus reset values

`timescale 1ns/1ps
`default_nettype none

module ro_cache_chk
  import ro_cache_cfg_pkg::*;
(
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  cpu_req_i,
  input addr_t cpu_addr_i,
  input logic  cpu_ack_i,
  input logic  flush_req_i,
  input logic  flush_ack_i,
  input logic  mem_req_i,
  input addr_t mem_addr_i,
  input logic  mem_ack_i
);

  int unsigned fail_count;

  initial fail_count = 0;

  // Reset values
  reset_outputs_low: assert property (@(posedge clk_i)
    !arst_n_i |-> !cpu_ack_i && !mem_req_i && !flush_ack_i)
    else begin
      $error("outputs not low during reset");
      fail_count++;
    end

  // --------------------
  // CPU port
  // --------------------
  cpu_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(cpu_ack_i) |-> cpu_req_i)
    else begin
      $error("cpu ack rose without a request");
      fail_count++;
    end

  cpu_ack_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cpu_req_i && cpu_ack_i |=> cpu_ack_i)
    else begin
      $error("cpu ack fell before the request");
      fail_count++;
    end

  cpu_req_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cpu_req_i && !cpu_ack_i |=> cpu_req_i && $stable(cpu_addr_i))
    else begin
      $error("cpu request not held until ack");
      fail_count++;
    end

  cpu_req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(cpu_req_i) |-> !cpu_ack_i)
    else begin
      $error("cpu request rose while ack high");
      fail_count++;
    end

  // --------------------
  // Memory and flush ports
  // --------------------
  mem_req_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i))
    else begin
      $error("memory request not held until ack");
      fail_count++;
    end

  mem_req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(mem_req_i) |-> !mem_ack_i)
    else begin
      $error("memory request rose while ack high");
      fail_count++;
    end

  flush_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(flush_ack_i) |-> flush_req_i)
    else begin
      $error("flush ack rose without a request");
      fail_count++;
    end

endmodule

bind ro_cache_top ro_cache_chk ro_cache_chk_i (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .cpu_req_i   (cpu_req_i),
  .cpu_addr_i  (cpu_addr_i),
  .cpu_ack_i   (cpu_ack_o),
  .flush_req_i (flush_req_i),
  .flush_ack_i (flush_ack_o),
  .mem_req_i   (mem_req_o),
  .mem_addr_i  (mem_addr_o),
  .mem_ack_i   (mem_ack_i)
);

`default_nettype wire

// File: bench/ro_tb_clock.sv
// Testbench clock and reset
// 20 ns clock, active low reset held for the first 16 rising edges

`timescale 1ns/1ps
`default_nettype none

module ro_tb_clock (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int unsigned HALF_PERIOD_NS = 10;
  localparam int unsigned RESET_CYCLES   = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release on a rising edge so every flop leaves reset together
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verilog/ro_cache_top.sv
// Read-only cache top level
// Region select, lookup, refill and memory arbiter chained on plain ports

`timescale 1ns/1ps
`default_nettype none

module ro_cache_top
  import ro_cache_cfg_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     enable_i,
  input  addr_t [REGION_COUNT-1:0] region_start_i,
  input  addr_t [REGION_COUNT-1:0] region_end_i,
  // CPU fetch port
  input  logic                     cpu_req_i,
  input  addr_t                    cpu_addr_i,
  output logic                     cpu_ack_o,
  output data_t                    cpu_data_o,
  output logic                     cpu_error_o,
  // Flush handshake
  input  logic                     flush_req_i,
  output logic                     flush_ack_o,
  // Memory port
  output logic                     mem_req_o,
  output addr_t                    mem_addr_o,
  input  logic                     mem_ack_i,
  input  data_t                    mem_data_i,
  input  logic                     mem_error_i
);

  ro_fetch_if cache_if ();
  ro_fetch_if bypass_if ();
  ro_fetch_if refill_if ();
  ro_miss_if  miss_if ();

  ro_region_select ro_region_select_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .enable_i       (enable_i),
    .region_start_i (region_start_i),
    .region_end_i   (region_end_i),
    .cpu_req_i      (cpu_req_i),
    .cpu_addr_i     (cpu_addr_i),
    .cpu_ack_o      (cpu_ack_o),
    .cpu_data_o     (cpu_data_o),
    .cpu_error_o    (cpu_error_o),
    .cache_o        (cache_if),
    .bypass_o       (bypass_if)
  );

  ro_cache_lookup ro_cache_lookup_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flush_req_i (flush_req_i),
    .flush_ack_o (flush_ack_o),
    .fetch_i     (cache_if),
    .miss_o      (miss_if)
  );

  ro_cache_refill ro_cache_refill_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .miss_i   (miss_if),
    .mem_o    (refill_if)
  );

  ro_mem_arbiter ro_mem_arbiter_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bypass_i    (bypass_if),
    .refill_i    (refill_if),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_data_i  (mem_data_i),
    .mem_error_i (mem_error_i)
  );

endmodule

`default_nettype wire

// File: verilog/ro_mem_arbiter.sv
// Memory port arbiter
// Shares the single memory port between the bypass and refill paths

`timescale 1ns/1ps
`default_nettype none

module ro_mem_arbiter
  import ro_cache_cfg_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  ro_fetch_if.responder bypass_i,
  ro_fetch_if.responder refill_i,
  output logic          mem_req_o,
  output addr_t         mem_addr_o,
  input  logic          mem_ack_i,
  input  data_t         mem_data_i,
  input  logic          mem_error_i
);

  grant_e grant_q;
  logic   refill_first_q;

  // Round robin on a tie, grant held through the whole handshake
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q        <= GRANT_NONE;
      refill_first_q <= 1'b0;
    end else begin
      unique case (grant_q)
        GRANT_NONE: begin
          if (refill_i.req && (refill_first_q || !bypass_i.req)) begin
            grant_q        <= GRANT_REFILL;
            refill_first_q <= 1'b0;
          end else if (bypass_i.req) begin
            grant_q        <= GRANT_BYPASS;
            refill_first_q <= 1'b1;
          end
        end
        GRANT_BYPASS: begin
          if (!bypass_i.req && !mem_ack_i) begin
            grant_q <= GRANT_NONE;
          end
        end
        GRANT_REFILL: begin
          if (!refill_i.req && !mem_ack_i) begin
            grant_q <= GRANT_NONE;
          end
        end
        default: grant_q <= GRANT_NONE;
      endcase
    end
  end

  // --------------------
  // Port forwarding
  // --------------------
  assign mem_req_o  = ((grant_q == GRANT_BYPASS) && bypass_i.req) ||
                      ((grant_q == GRANT_REFILL) && refill_i.req);
  assign mem_addr_o = (grant_q == GRANT_REFILL) ? refill_i.addr : bypass_i.addr;

  assign bypass_i.ack   = (grant_q == GRANT_BYPASS) && mem_ack_i;
  assign bypass_i.data  = mem_data_i;
  assign bypass_i.error = mem_error_i;

  assign refill_i.ack   = (grant_q == GRANT_REFILL) && mem_ack_i;
  assign refill_i.data  = mem_data_i;
  assign refill_i.error = mem_error_i;

endmodule

`default_nettype wire

// File: ro_cache/ro_cache_refill.sv
// Cache refill stage
// Fetches the words of one missing line from memory in address order

`timescale 1ns/1ps
`default_nettype none

module ro_cache_refill
  import ro_cache_cfg_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  ro_miss_if.responder  miss_i,
  ro_fetch_if.requester mem_o
);

  refill_state_e                state_q;
  logic [WORD_OFFSET_WIDTH-1:0] word_q;
  logic                         error_q;
  line_t                        line_q;
  logic                         last_word;

  assign last_word = (word_q == WORD_OFFSET_WIDTH'(LINE_WORDS - 1));

  // One four-phase memory handshake per word
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= REFILL_IDLE;
      word_q  <= '0;
      error_q <= 1'b0;
    end else begin
      unique case (state_q)
        REFILL_IDLE: begin
          if (miss_i.req) begin
            word_q  <= '0;
            error_q <= 1'b0;
            state_q <= REFILL_FETCH;
          end
        end
        REFILL_FETCH: begin
          if (mem_o.ack) begin
            error_q <= error_q | mem_o.error;
            state_q <= REFILL_RELEASE;
          end
        end
        REFILL_RELEASE: begin
          // Wait for memory to drop ack
          if (!mem_o.ack) begin
            if (last_word) begin
              state_q <= REFILL_DONE;
            end else begin
              word_q  <= word_q + 1'b1;
              state_q <= REFILL_FETCH;
            end
          end
        end
        REFILL_DONE: begin
          if (!miss_i.req) begin
            state_q <= REFILL_IDLE;
          end
        end
        default: state_q <= REFILL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == REFILL_FETCH && mem_o.ack) begin
      line_q[word_q] <= mem_o.data;
    end
  end

  assign mem_o.req  = (state_q == REFILL_FETCH);
  assign mem_o.addr = {miss_i.addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], word_q,
                       {BYTE_OFFSET_WIDTH{1'b0}}};

  assign miss_i.ack   = (state_q == REFILL_DONE);
  assign miss_i.line  = line_q;
  assign miss_i.error = error_q;

endmodule

`default_nettype wire

// File: ro_cache/ro_cache_lookup.sv
// Cache lookup stage
// Direct-mapped tag, data and valid arrays with hit check, line install
// after a refill, and invalidation of every line on a flush handshake

`timescale 1ns/1ps
`default_nettype none

module ro_cache_lookup
  import ro_cache_cfg_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          flush_req_i,
  output logic          flush_ack_o,
  ro_fetch_if.responder fetch_i,
  ro_miss_if.requester  miss_o
);

  lookup_state_e state_q;

  // Arrays
  tag_t                  tag_q  [LINE_COUNT];
  line_t                 data_q [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid_q;

  addr_t                        addr_q;
  tag_t                         req_tag;
  index_t                       req_index;
  logic [WORD_OFFSET_WIDTH-1:0] req_word;
  line_t                        rd_line;
  logic                         hit;
  logic                         install_en;
  data_t                        rsp_data_q;
  logic                         rsp_error_q;

  // --------------------
  // Address split
  // --------------------
  assign req_tag   = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_index = addr_q[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
  assign req_word  = addr_q[BYTE_OFFSET_WIDTH +: WORD_OFFSET_WIDTH];

  assign rd_line    = data_q[req_index];
  assign hit        = valid_q[req_index] && (tag_q[req_index] == req_tag);
  assign install_en = (state_q == LOOKUP_MISS_WAIT) && miss_o.ack && !miss_o.error;

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= LOOKUP_IDLE;
      valid_q     <= '0;
      rsp_error_q <= 1'b0;
    end else begin
      unique case (state_q)
        LOOKUP_IDLE: begin
          // Flush wins over a waiting fetch
          if (flush_req_i) begin
            valid_q <= '0;
            state_q <= LOOKUP_FLUSH;
          end else if (fetch_i.req) begin
            state_q <= LOOKUP_CHECK;
          end
        end
        LOOKUP_CHECK: begin
          if (hit) begin
            rsp_error_q <= 1'b0;
            state_q     <= LOOKUP_RESPOND;
          end else begin
            state_q <= LOOKUP_MISS_WAIT;
          end
        end
        LOOKUP_MISS_WAIT: begin
          if (miss_o.ack) begin
            rsp_error_q <= miss_o.error;
            if (install_en) begin
              valid_q[req_index] <= 1'b1;
            end
            state_q <= LOOKUP_RESPOND;
          end
        end
        LOOKUP_RESPOND: begin
          if (!fetch_i.req && !miss_o.ack) begin
            state_q <= LOOKUP_IDLE;
          end
        end
        LOOKUP_FLUSH: begin
          if (!flush_req_i) begin
            state_q <= LOOKUP_IDLE;
          end
        end
        default: state_q <= LOOKUP_IDLE;
      endcase
    end
  end

  // Tags, line data and response word
  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP_IDLE && fetch_i.req) begin
      addr_q <= fetch_i.addr;
    end
    if (install_en) begin
      tag_q[req_index]  <= req_tag;
      data_q[req_index] <= miss_o.line;
    end
    if (state_q == LOOKUP_CHECK) begin
      rsp_data_q <= rd_line[req_word];
    end else if (state_q == LOOKUP_MISS_WAIT && miss_o.ack) begin
      rsp_data_q <= miss_o.line[req_word];
    end
  end

  assign fetch_i.ack   = (state_q == LOOKUP_RESPOND);
  assign fetch_i.data  = rsp_data_q;
  assign fetch_i.error = rsp_error_q;

  assign miss_o.req  = (state_q == LOOKUP_MISS_WAIT);
  assign miss_o.addr = {addr_q[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};

  assign flush_ack_o = (state_q == LOOKUP_FLUSH);

endmodule

`default_nettype wire

// File: verilog/ro_region_select.sv
// Region select stage
// Routes each CPU read to the cache or the bypass path by address region

`timescale 1ns/1ps
`default_nettype none

module ro_region_select
  import ro_cache_cfg_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     enable_i,
  input  addr_t [REGION_COUNT-1:0] region_start_i,
  input  addr_t [REGION_COUNT-1:0] region_end_i,
  input  logic                     cpu_req_i,
  input  addr_t                    cpu_addr_i,
  output logic                     cpu_ack_o,
  output data_t                    cpu_data_o,
  output logic                     cpu_error_o,
  ro_fetch_if.requester            cache_o,
  ro_fetch_if.requester            bypass_o
);

  route_e route_d;
  route_e route_q;
  logic   busy_q;
  logic   fwd_q;
  logic   in_region;
  addr_t  addr_q;

  // Start inclusive, end exclusive
  always_comb begin
    in_region = 1'b0;
    for (int r = 0; r < REGION_COUNT; r++) begin
      if (cpu_addr_i >= region_start_i[r] && cpu_addr_i < region_end_i[r]) begin
        in_region = 1'b1;
      end
    end
  end

  assign route_d = (enable_i && in_region) ? ROUTE_CACHE : ROUTE_BYPASS;

  // Route held from rising req until the path ack has fallen
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      fwd_q   <= 1'b0;
      route_q <= ROUTE_BYPASS;
    end else if (!busy_q) begin
      if (cpu_req_i) begin
        busy_q  <= 1'b1;
        fwd_q   <= 1'b1;
        route_q <= route_d;
      end
    end else begin
      if (!cpu_req_i) begin
        fwd_q <= 1'b0;
      end
      if (!fwd_q && !cpu_ack_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_q && cpu_req_i) begin
      addr_q <= cpu_addr_i;
    end
  end

  assign cache_o.req   = fwd_q && (route_q == ROUTE_CACHE);
  assign cache_o.addr  = addr_q;
  assign bypass_o.req  = fwd_q && (route_q == ROUTE_BYPASS);
  assign bypass_o.addr = addr_q;

  // Response return from the selected path
  assign cpu_ack_o   = (route_q == ROUTE_CACHE) ? cache_o.ack   : bypass_o.ack;
  assign cpu_data_o  = (route_q == ROUTE_CACHE) ? cache_o.data  : bypass_o.data;
  assign cpu_error_o = (route_q == ROUTE_CACHE) ? cache_o.error : bypass_o.error;

endmodule

`default_nettype wire

// File: common/ro_fetch_if.sv
// Four-phase fetch interfaces of the read-only cache
// ro_fetch_if moves one word, ro_miss_if moves one whole cache line

`timescale 1ns/1ps
`default_nettype none

interface ro_fetch_if
  import ro_cache_cfg_pkg::*;
();

  logic  req;
  addr_t addr;
  logic  ack;
  data_t data;
  logic  error;

  modport requester (
    output req, addr,
    input  ack, data, error
  );

  modport responder (
    input  req, addr,
    output ack, data, error
  );

endinterface

interface ro_miss_if
  import ro_cache_cfg_pkg::*;
();

  // Line-aligned address of the missing line
  logic  req;
  addr_t addr;
  logic  ack;
  line_t line;
  logic  error;

  modport requester (
    output req, addr,
    input  ack, line, error
  );

  modport responder (
    input  req, addr,
    output ack, line, error
  );

endinterface

`default_nettype wire

// File: common/ro_cache_ctrl_pkg.sv
// Read-only cache control types
// Routing decision, stage state machines and memory port ownership

`default_nettype none

package ro_cache_ctrl_pkg;

  typedef enum logic {
    ROUTE_BYPASS,
    ROUTE_CACHE
  } route_e;

  typedef enum logic [2:0] {
    LOOKUP_IDLE,
    LOOKUP_CHECK,
    LOOKUP_MISS_WAIT,
    LOOKUP_RESPOND,
    LOOKUP_FLUSH
  } lookup_state_e;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_FETCH,
    REFILL_RELEASE,
    REFILL_DONE
  } refill_state_e;

  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_BYPASS,
    GRANT_REFILL
  } grant_e;

endpackage

`default_nettype wire

// File: common/ro_cache_cfg_pkg.sv
// Read-only cache configuration
// Address and data widths, cache geometry and the derived address split

`default_nettype none

package ro_cache_cfg_pkg;

  // --------------------
  // Widths and geometry
  // --------------------
  localparam int unsigned ADDR_WIDTH   = 32;
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned LINE_WORDS   = 2;
  localparam int unsigned LINE_COUNT   = 16;
  localparam int unsigned REGION_COUNT = 2;

  // Address split, from low to high: byte, word, index, tag
  localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(DATA_WIDTH / 8);
  localparam int unsigned WORD_OFFSET_WIDTH = $clog2(LINE_WORDS);
  localparam int unsigned LINE_OFFSET_WIDTH = WORD_OFFSET_WIDTH + BYTE_OFFSET_WIDTH;
  localparam int unsigned INDEX_WIDTH       = $clog2(LINE_COUNT);
  localparam int unsigned TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef data_t [LINE_WORDS-1:0] line_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;

endpackage

`default_nettype wire
